/* include/ids_defines.svh */
`ifndef IDS_DEFINES_SVH
`define IDS_DEFINES_SVH

// data path lanes
`define IDS_DATA_WIDTH      64
`define IDS_CTRL_WIDTH      8

// packet buffers
`define IDS_NUM_BUFFERS     8
`define IDS_BUF_SEL_WIDTH   3
`define IDS_BUF_ADDR_WIDTH  8   // 256 words per buffer

`define IDS_FIFO_DEPTH_BITS 2

// flow table and source ip position
`define IDS_FT_ADDR_WIDTH   4
`define IDS_FT_DEPTH        16
`define IDS_IP_WORD         4   // counted from the first payload word
`define IDS_IP_LSB          16

`endif

/* source/ids_pkg.sv */
`include "ids_defines.svh"

package ids_pkg;

	// parser only needs to know whether it is inside a packet
	typedef enum logic {
		idle,
		payload
	} parse_state_t;

	typedef struct packed {
		logic [`IDS_CTRL_WIDTH-1:0] ctrl;
		logic [`IDS_DATA_WIDTH-1:0] data;
	} pkt_word_t;

endpackage

/* source/pkt_buffer_if.sv */
`timescale 1ns/1ns

interface pkt_buffer_if;
	logic               wr;
	ids_pkg::pkt_word_t word;
	logic               last;
	logic               busy;     // holds an undrained packet
	logic               ready;    // complete packet waiting
	ids_pkg::pkt_word_t out_word;
	logic               out_last;
	logic               rd;

	modport writer (
		output wr, word, last,
		input  busy
	);

	modport store (
		input  wr, word, last, rd,
		output busy, ready, out_word, out_last
	);

	modport reader (
		input  ready, out_word, out_last,
		output rd
	);
endinterface

/* source/ingress_fifo.sv */
`timescale 1ns/1ns
`include "ids_defines.svh"

module ingress_fifo (
	input  logic               clk,
	input  logic               reset,
	input  ids_pkg::pkt_word_t din,
	input  logic               wr_en,
	input  logic               rd_en,
	output ids_pkg::pkt_word_t dout,
	output logic               empty,
	output logic               nearly_full
);
	localparam int DEPTH = 1 << `IDS_FIFO_DEPTH_BITS;
	localparam logic [`IDS_FIFO_DEPTH_BITS:0] NEARLY_LEVEL = (`IDS_FIFO_DEPTH_BITS+1)'(DEPTH - 1);

	ids_pkg::pkt_word_t mem [DEPTH];
	logic [`IDS_FIFO_DEPTH_BITS-1:0] wr_ptr;
	logic [`IDS_FIFO_DEPTH_BITS-1:0] rd_ptr;
	logic [`IDS_FIFO_DEPTH_BITS:0]   count;
	logic                            full;
	logic                            do_wr;
	logic                            do_rd;

	assign full        = count[`IDS_FIFO_DEPTH_BITS];  // count == DEPTH
	assign empty       = count == '0;
	assign nearly_full = count >= NEARLY_LEVEL;
	assign do_wr       = wr_en && !full;
	assign do_rd       = rd_en && !empty;
	assign dout        = mem[rd_ptr];  // fall-through head

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// upstream must respect in_rdy, which leaves one spare slot
	a_no_write_full: assert property (@(posedge clk) disable iff (reset) !(wr_en && full));
endmodule

/* source/packet_dispatcher.sv */
`timescale 1ns/1ns
`include "ids_defines.svh"

module packet_dispatcher (
	input  logic               clk,
	input  logic               reset,
	input  ids_pkg::pkt_word_t head,
	input  logic               empty,
	output logic               pop,
	pkt_buffer_if.writer       bufs [`IDS_NUM_BUFFERS],
	output logic [31:0]        lookup_ip,
	output logic               lookup_start,
	output logic [31:0]        num_packets
);
	localparam logic [`IDS_BUF_ADDR_WIDTH-1:0] IP_IDX = `IDS_BUF_ADDR_WIDTH'(`IDS_IP_WORD - 1);

	ids_pkg::parse_state_t           state;
	logic [`IDS_BUF_SEL_WIDTH-1:0]   sel;      // buffer being filled
	logic [`IDS_BUF_SEL_WIDTH-1:0]   wr_sel;
	logic [`IDS_BUF_ADDR_WIDTH-1:0]  pay_cnt;
	logic [`IDS_NUM_BUFFERS-1:0]     busy_vec;
	logic                            is_ctrl;
	logic                            ip_hit;
	logic                            wr_q;
	logic                            last_q;
	ids_pkg::pkt_word_t              word_q;

	genvar i;
	generate
		for (i = 0; i < `IDS_NUM_BUFFERS; i++) begin : g_buf
			assign busy_vec[i]  = bufs[i].busy;
			assign bufs[i].wr   = wr_q && (wr_sel == `IDS_BUF_SEL_WIDTH'(i));
			assign bufs[i].word = word_q;
			assign bufs[i].last = last_q;
		end
	endgenerate

	assign is_ctrl = head.ctrl != '0;
	// a packet in progress keeps its buffer, a new one waits for a free buffer
	assign pop     = !empty && (state == ids_pkg::payload || !busy_vec[sel]);
	assign ip_hit  = pop && state == ids_pkg::payload && !is_ctrl && pay_cnt == IP_IDX;

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= ids_pkg::idle;
			sel          <= '0;
			pay_cnt      <= '0;
			wr_q         <= 1'b0;
			lookup_start <= 1'b0;
			num_packets  <= '0;
		end else begin
			wr_q         <= 1'b0;
			lookup_start <= ip_hit;
			if (wr_q && last_q)
				num_packets <= num_packets + 32'd1;  // counted once closing word is stored
			if (pop) begin
				case (state)
					ids_pkg::idle: begin
						if (is_ctrl) begin  // stray payload words outside a packet are dropped
							state   <= ids_pkg::payload;
							pay_cnt <= '0;
							wr_q    <= 1'b1;
						end
					end
					ids_pkg::payload: begin
						wr_q <= 1'b1;
						if (is_ctrl) begin
							state <= ids_pkg::idle;
							sel   <= sel + 1'b1;  // round robin
						end else begin
							pay_cnt <= pay_cnt + 1'b1;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			word_q <= head;
			wr_sel <= sel;
			last_q <= state == ids_pkg::payload && is_ctrl;
		end
		if (ip_hit)
			lookup_ip <= head.data[`IDS_IP_LSB +: 32];
	end
endmodule

/* source/packet_buffer.sv */
`timescale 1ns/1ns
`include "ids_defines.svh"

module packet_buffer (
	input logic         clk,
	input logic         reset,
	pkt_buffer_if.store port
);
	localparam int DEPTH = 1 << `IDS_BUF_ADDR_WIDTH;

	ids_pkg::pkt_word_t              mem [DEPTH];
	logic [`IDS_BUF_ADDR_WIDTH:0]    wr_ptr;    // top bit set once memory is full
	logic [`IDS_BUF_ADDR_WIDTH-1:0]  rd_ptr;
	logic [`IDS_BUF_ADDR_WIDTH-1:0]  last_ptr;
	logic                            busy;
	logic                            ready;
	logic                            drained;

	assign drained       = port.rd && port.out_last;
	assign port.busy     = busy;
	assign port.ready    = ready;
	assign port.out_word = mem[rd_ptr];
	assign port.out_last = ready && rd_ptr == last_ptr;

	always_ff @(posedge clk) begin
		if (port.wr)
			mem[wr_ptr[`IDS_BUF_ADDR_WIDTH-1:0]] <= port.word;
		if (port.wr && port.last)
			last_ptr <= wr_ptr[`IDS_BUF_ADDR_WIDTH-1:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			busy   <= 1'b0;
			ready  <= 1'b0;
		end else if (drained) begin
			// whole packet gone, rewind for the next one
			wr_ptr <= '0;
			rd_ptr <= '0;
			busy   <= 1'b0;
			ready  <= 1'b0;
		end else begin
			if (port.wr) begin
				wr_ptr <= wr_ptr + 1'b1;
				busy   <= 1'b1;
				if (port.last)
					ready <= 1'b1;
			end
			if (port.rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		port.wr |-> !wr_ptr[`IDS_BUF_ADDR_WIDTH]);

	// dispatcher never appends to a finished packet
	a_no_write_ready: assert property (@(posedge clk) disable iff (reset) port.wr |-> !ready);
endmodule

/* source/egress_arbiter.sv */
`timescale 1ns/1ns
`include "ids_defines.svh"

module egress_arbiter (
	input  logic                       clk,
	input  logic                       reset,
	pkt_buffer_if.reader               bufs [`IDS_NUM_BUFFERS],
	input  logic                       out_rdy,
	output logic [`IDS_DATA_WIDTH-1:0] out_data,
	output logic [`IDS_CTRL_WIDTH-1:0] out_ctrl,
	output logic                       out_wr
);
	logic [`IDS_BUF_SEL_WIDTH-1:0] idx;  // same order the dispatcher fills
	logic [`IDS_NUM_BUFFERS-1:0]   ready_vec;
	logic [`IDS_NUM_BUFFERS-1:0]   last_vec;
	ids_pkg::pkt_word_t            words [`IDS_NUM_BUFFERS];
	logic                          take;

	genvar i;
	generate
		for (i = 0; i < `IDS_NUM_BUFFERS; i++) begin : g_buf
			assign ready_vec[i] = bufs[i].ready;
			assign last_vec[i]  = bufs[i].out_last;
			assign words[i]     = bufs[i].out_word;
			assign bufs[i].rd   = take && (idx == `IDS_BUF_SEL_WIDTH'(i));
		end
	endgenerate

	assign take = ready_vec[idx] && out_rdy;

	always_ff @(posedge clk) begin
		if (take) begin
			out_data <= words[idx].data;
			out_ctrl <= words[idx].ctrl;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			idx    <= '0;
			out_wr <= 1'b0;
		end else begin
			out_wr <= take;
			if (take && last_vec[idx])
				idx <= idx + 1'b1;  // packet done, move on
		end
	end

	a_out_wr_rdy: assert property (@(posedge clk) disable iff (reset) out_wr |-> $past(out_rdy));
endmodule

/* source/flow_table.sv */
`timescale 1ns/1ns
`include "ids_defines.svh"

module flow_table (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         ft_wr,
	input  logic [`IDS_FT_ADDR_WIDTH-1:0] ft_addr,
	input  logic [31:0]                  ft_ip,
	input  logic                         ft_valid,
	input  logic [31:0]                  lookup_ip,
	input  logic                         lookup_start,
	output logic                         match_pulse,
	output logic [31:0]                  num_matches
);
	logic [31:0]              ip_mem [`IDS_FT_DEPTH];
	logic [`IDS_FT_DEPTH-1:0] valid;
	logic [`IDS_FT_DEPTH-1:0] hit_vec;
	logic                     hit;

	genvar i;
	generate
		for (i = 0; i < `IDS_FT_DEPTH; i++) begin : g_cmp
			assign hit_vec[i] = valid[i] && ip_mem[i] == lookup_ip;  // all entries at once
		end
	endgenerate

	assign hit = lookup_start && |hit_vec;

	always_ff @(posedge clk) begin
		if (ft_wr)
			ip_mem[ft_addr] <= ft_ip;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid       <= '0;
			match_pulse <= 1'b0;
			num_matches <= '0;
		end else begin
			if (ft_wr)
				valid[ft_addr] <= ft_valid;  // clearing valid retires an entry
			match_pulse <= hit;
			if (hit)
				num_matches <= num_matches + 32'd1;
		end
	end
endmodule

/* source/ids_top.sv */
`timescale 1ns/1ns
`include "ids_defines.svh"

module ids_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [`IDS_DATA_WIDTH-1:0]    in_data,
	input  logic [`IDS_CTRL_WIDTH-1:0]    in_ctrl,
	input  logic                          in_wr,
	output logic                          in_rdy,
	output logic [`IDS_DATA_WIDTH-1:0]    out_data,
	output logic [`IDS_CTRL_WIDTH-1:0]    out_ctrl,
	output logic                          out_wr,
	input  logic                          out_rdy,
	input  logic                          ft_wr,
	input  logic [`IDS_FT_ADDR_WIDTH-1:0] ft_addr,
	input  logic [31:0]                   ft_ip,
	input  logic                          ft_valid,
	output logic [31:0]                   num_packets,
	output logic [31:0]                   num_matches
);
	ids_pkg::pkt_word_t fifo_head;
	logic               fifo_empty;
	logic               fifo_nearly_full;
	logic               fifo_pop;
	logic [31:0]        lookup_ip;
	logic               lookup_start;

	pkt_buffer_if bufs [`IDS_NUM_BUFFERS] ();

	assign in_rdy = !fifo_nearly_full;

	ingress_fifo u_ingress_fifo (
		.clk         (clk),
		.reset       (reset),
		.din         ({in_ctrl, in_data}),
		.wr_en       (in_wr),
		.rd_en       (fifo_pop),
		.dout        (fifo_head),
		.empty       (fifo_empty),
		.nearly_full (fifo_nearly_full)
	);

	packet_dispatcher u_packet_dispatcher (
		.clk          (clk),
		.reset        (reset),
		.head         (fifo_head),
		.empty        (fifo_empty),
		.pop          (fifo_pop),
		.bufs         (bufs),
		.lookup_ip    (lookup_ip),
		.lookup_start (lookup_start),
		.num_packets  (num_packets)
	);

	genvar i;
	generate
		for (i = 0; i < `IDS_NUM_BUFFERS; i++) begin : g_buf
			packet_buffer u_packet_buffer (
				.clk   (clk),
				.reset (reset),
				.port  (bufs[i])
			);
		end
	endgenerate

	egress_arbiter u_egress_arbiter (
		.clk      (clk),
		.reset    (reset),
		.bufs     (bufs),
		.out_rdy  (out_rdy),
		.out_data (out_data),
		.out_ctrl (out_ctrl),
		.out_wr   (out_wr)
	);

	flow_table u_flow_table (
		.clk          (clk),
		.reset        (reset),
		.ft_wr        (ft_wr),
		.ft_addr      (ft_addr),
		.ft_ip        (ft_ip),
		.ft_valid     (ft_valid),
		.lookup_ip    (lookup_ip),
		.lookup_start (lookup_start),
		.match_pulse  (),
		.num_matches  (num_matches)
	);
endmodule

/* verification/ids_tb.sv */
`timescale 1ns/1ns
`include "ids_defines.svh"

module ids_tb;
	localparam int NUM_PKTS = 60;
	localparam int TIMEOUT  = 5000;

	logic                          clk = 1'b0;
	logic                          reset;
	logic [`IDS_DATA_WIDTH-1:0]    in_data;
	logic [`IDS_CTRL_WIDTH-1:0]    in_ctrl;
	logic                          in_wr;
	logic                          in_rdy;
	logic [`IDS_DATA_WIDTH-1:0]    out_data;
	logic [`IDS_CTRL_WIDTH-1:0]    out_ctrl;
	logic                          out_wr;
	logic                          out_rdy;
	logic                          ft_wr;
	logic [`IDS_FT_ADDR_WIDTH-1:0] ft_addr;
	logic [31:0]                   ft_ip;
	logic                          ft_valid;
	logic [31:0]                   num_packets;
	logic [31:0]                   num_matches;

	logic [71:0] sent_q [$];  // words in arrival order
	logic [71:0] exp_word;
	logic [31:0] seed = 32'h6b0d_eb35;
	logic [31:0] rdy_seed = 32'h6b0d_eb35;
	logic [31:0] tbl_ip [`IDS_FT_DEPTH];
	logic        tbl_ok [`IDS_FT_DEPTH];
	logic        stall;
	int          errors;
	int          pkts_sent;
	int          exp_matches;
	int          waited;

	ids_top u_ids_top (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_rand();
		seed = xorshift(seed);
		return seed;
	endfunction

	task automatic give_up(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("Errors found");
		$finish;
	endtask

	task automatic program_entry(input int idx, input logic [31:0] ip, input logic ok);
		ft_wr    = 1'b1;
		ft_addr  = `IDS_FT_ADDR_WIDTH'(idx);
		ft_ip    = ip;
		ft_valid = ok;
		tbl_ip[idx] = ip;
		tbl_ok[idx] = ok;
		@(posedge clk);
		#1;
		ft_wr = 1'b0;
	endtask

	task automatic send_word(input logic [7:0] c, input logic [63:0] d);
		int w;
		w = 0;
		while (!in_rdy) begin
			@(posedge clk);
			#1;
			w++;
			if (w > TIMEOUT)
				give_up("in_rdy stayed low");
		end
		in_wr   = 1'b1;
		in_ctrl = c;
		in_data = d;
		sent_q.push_back({c, d});
		@(posedge clk);
		#1;
		in_wr = 1'b0;
	endtask

	task automatic send_packets(input int count);
		int          len;
		logic [31:0] ip;
		logic [63:0] d;
		logic        hit;
		for (int p = 0; p < count; p++) begin
			len = int'(next_rand() % 40) + 1;
			ip  = next_rand();
			if (next_rand() % 2 == 0)
				ip = tbl_ip[4'(next_rand() % 6)];  // aim at the table now and then
			send_word(8'(next_rand() % 255) + 8'd1, {next_rand(), next_rand()});
			for (int w = 0; w < len; w++) begin
				d = {next_rand(), next_rand()};
				if (w == `IDS_IP_WORD - 1)
					d[`IDS_IP_LSB +: 32] = ip;
				send_word(8'd0, d);
			end
			send_word(8'(next_rand() % 255) + 8'd1, {next_rand(), next_rand()});
			hit = 1'b0;
			for (int i = 0; i < `IDS_FT_DEPTH; i++)
				if (tbl_ok[i] && tbl_ip[i] == ip)
					hit = 1'b1;
			if (len >= `IDS_IP_WORD && hit)
				exp_matches++;
			pkts_sent++;
		end
	endtask

	task automatic stall_phase();
		int w;
		repeat (150) @(posedge clk);
		stall = 1'b1;
		#1;
		w = 0;
		while (in_rdy) begin
			@(posedge clk);
			#1;
			w++;
			if (w > TIMEOUT)
				give_up("in_rdy never fell while the output was stalled");
		end
		repeat (40) @(posedge clk);
		stall = 1'b0;
	endtask

	// random gaps on out_rdy, held low during the stall
	always begin
		@(posedge clk);
		#1;
		rdy_seed = xorshift(rdy_seed);
		out_rdy  = !stall && rdy_seed[1:0] != 2'b00;
	end

	always @(negedge clk) begin
		if (!reset && out_wr) begin
			if (sent_q.size() == 0) begin
				errors++;
				$display("Error at %0t: output word with nothing queued", $time);
			end else begin
				exp_word = sent_q.pop_front();
				assert ({out_ctrl, out_data} == exp_word) else begin
					errors++;
					$display("Error at %0t: out word %h, expected %h", $time,
						{out_ctrl, out_data}, exp_word);
				end
			end
		end
	end

	a_out_wr_rdy: assert property (@(posedge clk) disable iff (reset) out_wr |-> $past(out_rdy))
		else begin
			errors++;
			$display("Error at %0t: out_wr high after out_rdy was low", $time);
		end

	initial begin
		reset    = 1'b1;
		in_data  = '0;
		in_ctrl  = '0;
		in_wr    = 1'b0;
		out_rdy  = 1'b0;
		ft_wr    = 1'b0;
		ft_addr  = '0;
		ft_ip    = '0;
		ft_valid = 1'b0;
		stall    = 1'b0;
		errors   = 0;
		pkts_sent   = 0;
		exp_matches = 0;
		for (int i = 0; i < `IDS_FT_DEPTH; i++) begin
			tbl_ip[i] = '0;
			tbl_ok[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		assert (!out_wr && num_packets == 32'd0 && num_matches == 32'd0) else begin
			errors++;
			$display("Error at %0t: outputs not cleared by reset", $time);
		end

		for (int i = 0; i < 6; i++)
			program_entry(i, next_rand(), 1'b1);
		program_entry(5, tbl_ip[5], 1'b0);  // retired entry must stop matching

		fork
			send_packets(NUM_PKTS);
			stall_phase();
		join

		waited = 0;
		while (sent_q.size() != 0) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > TIMEOUT)
				give_up("traffic did not drain");
		end
		assert (num_packets == 32'(pkts_sent)) else begin
			errors++;
			$display("Error at %0t: num_packets %0d, expected %0d", $time,
				num_packets, pkts_sent);
		end
		assert (num_matches == 32'(exp_matches)) else begin
			errors++;
			$display("Error at %0t: num_matches %0d, expected %0d", $time,
				num_matches, exp_matches);
		end

		$display("%0d errors over %0d packets and %0d matches", errors, pkts_sent, exp_matches);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end
endmodule

/* ids.f */
+incdir+include
source/ids_pkg.sv
source/pkt_buffer_if.sv
source/ingress_fifo.sv
source/packet_dispatcher.sv
source/packet_buffer.sv
source/egress_arbiter.sv
source/flow_table.sv
source/ids_top.sv
verification/ids_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ids_tb
FILELIST  ?= ids.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Iinclude

SRCS := $(shell grep -v '^+' $(FILELIST)) include/ids_defines.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
